// File: rtl/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Integer register and data path width
`define XLEN 32

// Architectural registers, x0 included
`define NUM_GPR 32

// Debug bus word address, one word per register
`define DBG_ADDR_W 5

`endif

// File: rtl/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]            xlen_t;
    typedef logic [$clog2(`NUM_GPR)-1:0] reg_addr_t;
    typedef logic [31:0]                 inst_t;
    typedef logic [3:0]                  alu_op_t;
    typedef logic [(`XLEN/8)-1:0]        mem_byte_t;

    // ALU operation codes seen by the execute stage
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // Debug bus slave
    typedef enum logic {
        WB_IDLE = 1'b0,
        WB_RESP = 1'b1
    } wb_state_e;

endpackage

// File: rtl/dbg_gpr_if.sv
`timescale 1ns/1ps

interface dbg_gpr_if;
    import cpu_pkg::*;

    logic      req;
    logic      we;
    reg_addr_t addr;
    xlen_t     wdata;
    xlen_t     rdata;

    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// File: rtl/rfu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module rfu (
    input  logic               clk,
    input  logic               arst_n_i,
    input  cpu_pkg::reg_addr_t rs1_addr_i,
    input  cpu_pkg::reg_addr_t rs2_addr_i,
    output cpu_pkg::xlen_t     rs1_data_o,
    output cpu_pkg::xlen_t     rs2_data_o,
    input  logic               rd_wr_i,
    input  cpu_pkg::reg_addr_t rd_addr_i,
    input  cpu_pkg::xlen_t     rd_data_i,
    input  logic               halted_i,
    dbg_gpr_if.slave           dbg
);
    import cpu_pkg::*;

    xlen_t     gpr_q [1:`NUM_GPR-1];
    logic      pipe_wr;
    logic      wr_en;
    reg_addr_t wr_addr;
    xlen_t     wr_data;

    // Write-back is ignored while halted
    assign pipe_wr = rd_wr_i && !halted_i;

    // Debug owns the write port when the core is halted
    assign wr_en   = halted_i ? (dbg.req && dbg.we) : pipe_wr;
    assign wr_addr = halted_i ? dbg.addr : rd_addr_i;
    assign wr_data = halted_i ? dbg.wdata : rd_data_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `NUM_GPR; i++) begin
                gpr_q[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            gpr_q[wr_addr] <= wr_data;
        end
    end

    function automatic xlen_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        // Forward the value being written back this cycle
        if (pipe_wr && (rd_addr_i == addr)) begin
            return rd_data_i;
        end
        return gpr_q[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    assign dbg.rdata = (dbg.addr == '0) ? '0 : gpr_q[dbg.addr];

endmodule

// File: rtl/dec.sv
`timescale 1ns/1ps

module dec (
    input  cpu_pkg::inst_t     inst_i,
    input  logic               inst_valid_i,
    output cpu_pkg::reg_addr_t rs1_addr_o,
    output cpu_pkg::reg_addr_t rs2_addr_o,
    output cpu_pkg::reg_addr_t rd_addr_o,
    output cpu_pkg::xlen_t     imm_o,
    output cpu_pkg::alu_op_t   alu_op_o,
    output logic               rs1_rd_o,
    output logic               rs2_rd_o,
    output logic               rs1_zero_sel_o,
    output logic               rs2_imm_sel_o,
    output logic               pc_imm_sel_o,
    output logic               branch_o,
    output logic               jump_o,
    output logic               jump_alu_o,
    output logic               mem_req_o,
    output logic               mem_wr_o,
    output cpu_pkg::mem_byte_t mem_byte_o,
    output logic               mem_sign_ext_o,
    output logic               pc_alu_sel_o,
    output logic               mem_cal_sel_o,
    output logic               rd_wr_o,
    output logic               ill_inst_o,
    output logic               fence_o,
    output logic               ecall_o,
    output logic               ebreak_o
);
    import cpu_pkg::*;

    localparam logic [6:0] OP_LUI      = 7'b0110111;
    localparam logic [6:0] OP_AUIPC    = 7'b0010111;
    localparam logic [6:0] OP_JAL      = 7'b1101111;
    localparam logic [6:0] OP_JALR     = 7'b1100111;
    localparam logic [6:0] OP_BRANCH   = 7'b1100011;
    localparam logic [6:0] OP_LOAD     = 7'b0000011;
    localparam logic [6:0] OP_STORE    = 7'b0100011;
    localparam logic [6:0] OP_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_OP       = 7'b0110011;
    localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM   = 7'b1110011;
    localparam inst_t      INST_ECALL  = 32'h0000_0073;
    localparam inst_t      INST_EBREAK = 32'h0010_0073;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    logic       rd_nz;
    mem_byte_t  byte_mask;

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];
    assign rd_nz      = (inst_i[11:7] != '0);
    assign byte_mask  = (funct3[1:0] == 2'b00) ? 4'b0001 :
                        (funct3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
    assign ill_inst_o = inst_valid_i && !legal;

    function automatic alu_op_t alu_sel(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC, OP_JAL: legal = 1'b1;
            OP_JALR:     legal = (funct3 == 3'b000);
            OP_BRANCH:   legal = (funct3[2:1] != 2'b01);
            OP_LOAD:     legal = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
            OP_STORE:    legal = !funct3[2] && (funct3 != 3'b011);
            OP_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    legal = 1'b1;
                end
            end
            OP_OP:       legal = (funct7 == 7'b0000000) ||
                                 ((funct7 == 7'b0100000) &&
                                  ((funct3 == 3'b000) || (funct3 == 3'b101)));
            OP_MISC_MEM: legal = (funct3 == 3'b000);
            OP_SYSTEM:   legal = (inst_i == INST_ECALL) || (inst_i == INST_EBREAK);
            default:     legal = 1'b0;
        endcase
    end

    // Immediate by format
    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC: imm_o = {inst_i[31:12], 12'b0};
            OP_JAL:    imm_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20],
                                inst_i[30:21], 1'b0};
            OP_BRANCH: imm_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25],
                                inst_i[11:8], 1'b0};
            OP_STORE:  imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            OP_JALR, OP_LOAD, OP_OP_IMM: imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
            default:   imm_o = '0;
        endcase
    end

    always_comb begin
        alu_op_o       = ALU_ADD;
        rs1_rd_o       = 1'b0;
        rs2_rd_o       = 1'b0;
        rs1_zero_sel_o = 1'b0;
        rs2_imm_sel_o  = 1'b0;
        pc_imm_sel_o   = 1'b0;
        branch_o       = 1'b0;
        jump_o         = 1'b0;
        jump_alu_o     = 1'b0;
        mem_req_o      = 1'b0;
        mem_wr_o       = 1'b0;
        mem_byte_o     = '0;
        mem_sign_ext_o = 1'b0;
        pc_alu_sel_o   = 1'b0;
        mem_cal_sel_o  = 1'b0;
        rd_wr_o        = 1'b0;
        fence_o        = 1'b0;
        ecall_o        = 1'b0;
        ebreak_o       = 1'b0;
        if (inst_valid_i && legal) begin
            case (opcode)
                OP_LUI: begin
                    rs1_zero_sel_o = 1'b1;
                    rs2_imm_sel_o  = 1'b1;
                    rd_wr_o        = rd_nz;
                end
                OP_AUIPC: begin
                    pc_imm_sel_o = 1'b1;
                    rd_wr_o      = rd_nz;
                end
                OP_JAL: begin
                    jump_o       = 1'b1;
                    pc_imm_sel_o = 1'b1;
                    pc_alu_sel_o = 1'b1;
                    rd_wr_o      = rd_nz;
                end
                OP_JALR: begin
                    jump_o        = 1'b1;
                    jump_alu_o    = 1'b1;
                    rs1_rd_o      = 1'b1;
                    rs2_imm_sel_o = 1'b1;
                    pc_alu_sel_o  = 1'b1;
                    rd_wr_o       = rd_nz;
                end
                OP_BRANCH: begin
                    branch_o     = 1'b1;
                    rs1_rd_o     = 1'b1;
                    rs2_rd_o     = 1'b1;
                    pc_imm_sel_o = 1'b1;
                    // Signed or unsigned compare, equality by subtraction
                    alu_op_o     = !funct3[2] ? ALU_SUB : (funct3[1] ? ALU_SLTU : ALU_SLT);
                end
                OP_LOAD: begin
                    mem_req_o      = 1'b1;
                    rs1_rd_o       = 1'b1;
                    rs2_imm_sel_o  = 1'b1;
                    mem_byte_o     = byte_mask;
                    mem_sign_ext_o = !funct3[2];
                    mem_cal_sel_o  = 1'b1;
                    rd_wr_o        = rd_nz;
                end
                OP_STORE: begin
                    mem_req_o     = 1'b1;
                    mem_wr_o      = 1'b1;
                    rs1_rd_o      = 1'b1;
                    rs2_rd_o      = 1'b1;
                    rs2_imm_sel_o = 1'b1;
                    mem_byte_o    = byte_mask;
                end
                OP_OP_IMM: begin
                    rs1_rd_o      = 1'b1;
                    rs2_imm_sel_o = 1'b1;
                    alu_op_o      = alu_sel(funct3, (funct3 == 3'b101) && inst_i[30]);
                    rd_wr_o       = rd_nz;
                end
                OP_OP: begin
                    rs1_rd_o = 1'b1;
                    rs2_rd_o = 1'b1;
                    alu_op_o = alu_sel(funct3, inst_i[30]);
                    rd_wr_o  = rd_nz;
                end
                OP_MISC_MEM: fence_o = 1'b1;
                default: begin
                    ecall_o  = (inst_i == INST_ECALL);
                    ebreak_o = (inst_i == INST_EBREAK);
                end
            endcase
        end
    end

endmodule

// File: rtl/dbg_wb_slave.sv
`timescale 1ns/1ps

module dbg_wb_slave (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  cpu_pkg::reg_addr_t wb_adr_i,
    input  cpu_pkg::xlen_t     wb_dat_i,
    output cpu_pkg::xlen_t     wb_dat_o,
    output logic               wb_ack_o,
    output logic               wb_err_o,
    input  logic               halted_i,
    dbg_gpr_if.master          gpr
);
    import cpu_pkg::*;

    wb_state_e state_q;
    logic      wb_req;

    // New requests are taken only in idle
    assign wb_req = wb_cyc_i && wb_stb_i && (state_q == WB_IDLE);

    // Register file is touched only while halted
    assign gpr.req   = wb_req && halted_i;
    assign gpr.we    = wb_we_i;
    assign gpr.addr  = wb_adr_i;
    assign gpr.wdata = wb_dat_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= WB_IDLE;
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
            case (state_q)
                WB_IDLE: begin
                    if (wb_req) begin
                        state_q  <= WB_RESP;
                        wb_ack_o <= halted_i;
                        wb_err_o <= !halted_i;
                        if (halted_i && !wb_we_i) begin
                            wb_dat_o <= gpr.rdata;
                        end
                    end
                end
                default: state_q <= WB_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/idu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module idu (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  cpu_pkg::inst_t         inst_i,
    input  logic                   inst_valid_i,
    input  logic                   rd_wr_i,
    input  cpu_pkg::reg_addr_t     rd_addr_i,
    input  cpu_pkg::xlen_t         rd_data_i,
    input  logic                   halted_i,

    // Debug bus
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [`DBG_ADDR_W-1:0] wb_adr_i,
    input  cpu_pkg::xlen_t         wb_dat_i,
    output cpu_pkg::xlen_t         wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   wb_err_o,

    // Operands
    output cpu_pkg::reg_addr_t     rs1_addr_o,
    output cpu_pkg::reg_addr_t     rs2_addr_o,
    output cpu_pkg::reg_addr_t     rd_addr_o,
    output cpu_pkg::xlen_t         rs1_data_o,
    output cpu_pkg::xlen_t         rs2_data_o,
    output cpu_pkg::xlen_t         imm_o,

    // Stage controls
    output cpu_pkg::alu_op_t       alu_op_o,
    output logic                   rs1_rd_o,
    output logic                   rs2_rd_o,
    output logic                   rs1_zero_sel_o,
    output logic                   rs2_imm_sel_o,
    output logic                   pc_imm_sel_o,
    output logic                   branch_o,
    output logic                   jump_o,
    output logic                   jump_alu_o,
    output logic                   mem_req_o,
    output logic                   mem_wr_o,
    output cpu_pkg::mem_byte_t     mem_byte_o,
    output logic                   mem_sign_ext_o,
    output logic                   pc_alu_sel_o,
    output logic                   mem_cal_sel_o,
    output logic                   rd_wr_o,
    output logic                   ill_inst_o,
    output logic                   fence_o,
    output logic                   ecall_o,
    output logic                   ebreak_o
);

    dbg_gpr_if u_gpr_if ();

    rfu u_rfu (
        .clk        ( clk            ),
        .arst_n_i   ( arst_n_i       ),
        .rs1_addr_i ( rs1_addr_o     ),
        .rs2_addr_i ( rs2_addr_o     ),
        .rs1_data_o ( rs1_data_o     ),
        .rs2_data_o ( rs2_data_o     ),
        .rd_wr_i    ( rd_wr_i        ),
        .rd_addr_i  ( rd_addr_i      ),
        .rd_data_i  ( rd_data_i      ),
        .halted_i   ( halted_i       ),
        .dbg        ( u_gpr_if.slave )
    );

    dec u_dec (
        .inst_i         ( inst_i         ),
        .inst_valid_i   ( inst_valid_i   ),
        .rs1_addr_o     ( rs1_addr_o     ),
        .rs2_addr_o     ( rs2_addr_o     ),
        .rd_addr_o      ( rd_addr_o      ),
        .imm_o          ( imm_o          ),
        .alu_op_o       ( alu_op_o       ),
        .rs1_rd_o       ( rs1_rd_o       ),
        .rs2_rd_o       ( rs2_rd_o       ),
        .rs1_zero_sel_o ( rs1_zero_sel_o ),
        .rs2_imm_sel_o  ( rs2_imm_sel_o  ),
        .pc_imm_sel_o   ( pc_imm_sel_o   ),
        .branch_o       ( branch_o       ),
        .jump_o         ( jump_o         ),
        .jump_alu_o     ( jump_alu_o     ),
        .mem_req_o      ( mem_req_o      ),
        .mem_wr_o       ( mem_wr_o       ),
        .mem_byte_o     ( mem_byte_o     ),
        .mem_sign_ext_o ( mem_sign_ext_o ),
        .pc_alu_sel_o   ( pc_alu_sel_o   ),
        .mem_cal_sel_o  ( mem_cal_sel_o  ),
        .rd_wr_o        ( rd_wr_o        ),
        .ill_inst_o     ( ill_inst_o     ),
        .fence_o        ( fence_o        ),
        .ecall_o        ( ecall_o        ),
        .ebreak_o       ( ebreak_o       )
    );

    dbg_wb_slave u_dbg (
        .clk      ( clk             ),
        .arst_n_i ( arst_n_i        ),
        .wb_cyc_i ( wb_cyc_i        ),
        .wb_stb_i ( wb_stb_i        ),
        .wb_we_i  ( wb_we_i         ),
        .wb_adr_i ( wb_adr_i        ),
        .wb_dat_i ( wb_dat_i        ),
        .wb_dat_o ( wb_dat_o        ),
        .wb_ack_o ( wb_ack_o        ),
        .wb_err_o ( wb_err_o        ),
        .halted_i ( halted_i        ),
        .gpr      ( u_gpr_if.master )
    );

endmodule

// File: bench/idu_tb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module idu_tb;
    import cpu_pkg::*;

    localparam int PERIOD = 100;
    localparam int N_REG  = 200;
    localparam int N_DEC  = 400;
    localparam int N_DBG  = 100;
    localparam int N_ERR  = 20;
    localparam int N_OPS  = N_REG + N_DEC + 2 * N_DBG + 2 * N_ERR;

    localparam logic [6:0] OPC_LUI    = 7'h37;
    localparam logic [6:0] OPC_AUIPC  = 7'h17;
    localparam logic [6:0] OPC_JAL    = 7'h6f;
    localparam logic [6:0] OPC_JALR   = 7'h67;
    localparam logic [6:0] OPC_BRANCH = 7'h63;
    localparam logic [6:0] OPC_LOAD   = 7'h03;
    localparam logic [6:0] OPC_STORE  = 7'h23;
    localparam logic [6:0] OPC_IMM    = 7'h13;
    localparam logic [6:0] OPC_REG    = 7'h33;
    localparam logic [6:0] OPC_FENCE  = 7'h0f;
    localparam logic [6:0] OPC_SYS    = 7'h73;

    logic clk;
    logic arst_n_i;
    inst_t inst_i;
    logic inst_valid_i;
    logic rd_wr_i;
    reg_addr_t rd_addr_i;
    xlen_t rd_data_i;
    logic halted_i;
    logic wb_cyc_i;
    logic wb_stb_i;
    logic wb_we_i;
    logic [`DBG_ADDR_W-1:0] wb_adr_i;
    xlen_t wb_dat_i;
    xlen_t wb_dat_o;
    logic wb_ack_o;
    logic wb_err_o;
    reg_addr_t rs1_addr_o;
    reg_addr_t rs2_addr_o;
    reg_addr_t rd_addr_o;
    xlen_t rs1_data_o;
    xlen_t rs2_data_o;
    xlen_t imm_o;
    alu_op_t alu_op_o;
    logic rs1_rd_o;
    logic rs2_rd_o;
    logic rs1_zero_sel_o;
    logic rs2_imm_sel_o;
    logic pc_imm_sel_o;
    logic branch_o;
    logic jump_o;
    logic jump_alu_o;
    logic mem_req_o;
    logic mem_wr_o;
    mem_byte_t mem_byte_o;
    logic mem_sign_ext_o;
    logic pc_alu_sel_o;
    logic mem_cal_sel_o;
    logic rd_wr_o;
    logic ill_inst_o;
    logic fence_o;
    logic ecall_o;
    logic ebreak_o;

    // Expected decode in the bit order of check_decode
    logic [17:0] e_ctl;
    xlen_t       e_imm;
    alu_op_t     e_alu;
    mem_byte_t   e_byte;
    xlen_t       regs [0:31];
    logic [15:0] lfsr_q = 16'd15;

    idu dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((N_OPS * 2 + 100 + 16) * PERIOD);
        $display("Timeout: the tests did not finish in time");
        $display("Checks failed");
        $fatal(1);
    end

    // x16 + x14 + x13 + x11 + 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    function automatic alu_op_t alu_of(logic [2:0] f3, logic alt);
        case (f3)
            3'd0:    return alt ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    task automatic model_decode(logic [31:0] w, logic v);
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        logic legal;
        logic rdnz;
        op = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        rdnz = (w[11:7] != 5'd0);
        case (op)
            OPC_LUI, OPC_AUIPC: e_imm = {w[31:12], 12'd0};
            OPC_JAL:    e_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            OPC_BRANCH: e_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OPC_STORE:  e_imm = {{20{w[31]}}, w[31:25], w[11:7]};
            OPC_JALR, OPC_LOAD, OPC_IMM: e_imm = {{20{w[31]}}, w[31:20]};
            default:    e_imm = '0;
        endcase
        case (op)
            OPC_LUI, OPC_AUIPC, OPC_JAL: legal = 1'b1;
            OPC_JALR:   legal = (f3 == 3'd0);
            OPC_BRANCH: legal = (f3 != 3'd2) && (f3 != 3'd3);
            OPC_LOAD:   legal = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd2) ||
                                (f3 == 3'd4) || (f3 == 3'd5);
            OPC_STORE:  legal = (f3 <= 3'd2);
            OPC_IMM:    legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                                (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
            OPC_REG:    legal = (f7 == 7'h00) ||
                                (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            OPC_FENCE:  legal = (f3 == 3'd0);
            OPC_SYS:    legal = (w == 32'h73) || (w == 32'h0010_0073);
            default:    legal = 1'b0;
        endcase
        e_ctl = '0;
        e_alu = ALU_ADD;
        e_byte = '0;
        e_ctl[3] = v && !legal;
        if (v && legal) begin
            // Bits 17 down to 0 are rs1_rd rs2_rd zero_sel imm_sel pc_imm branch jump
            // jump_alu mem_req mem_wr sign_ext pc_alu cal_sel rd_wr ill fence ecall ebreak
            case (op)
                OPC_LUI:    e_ctl = {4'b0011, 9'd0, rdnz, 4'd0};
                OPC_AUIPC:  e_ctl = {5'b00001, 8'd0, rdnz, 4'd0};
                OPC_JAL:    e_ctl = {5'b00001, 2'b01, 4'd0, 2'b10, rdnz, 4'd0};
                OPC_JALR:   e_ctl = {4'b1001, 3'b001, 1'b1, 3'd0, 2'b10, rdnz, 4'd0};
                OPC_BRANCH: begin
                    e_ctl = {5'b11001, 1'b1, 12'd0};
                    case (f3)
                        3'd4, 3'd5: e_alu = ALU_SLT;
                        3'd6, 3'd7: e_alu = ALU_SLTU;
                        default:    e_alu = ALU_SUB;
                    endcase
                end
                OPC_LOAD: begin
                    e_ctl = {4'b1001, 4'd0, 2'b10, !f3[2], 2'b01, rdnz, 4'd0};
                    // Access of 2**size bytes
                    e_byte = 4'((1 << (1 << f3[1:0])) - 1);
                end
                OPC_STORE: begin
                    e_ctl = {4'b1101, 4'd0, 2'b11, 8'd0};
                    e_byte = 4'((1 << (1 << f3[1:0])) - 1);
                end
                OPC_IMM: begin
                    e_ctl = {4'b1001, 9'd0, rdnz, 4'd0};
                    e_alu = alu_of(f3, (f3 == 3'd5) && w[30]);
                end
                OPC_REG: begin
                    e_ctl = {4'b1100, 9'd0, rdnz, 4'd0};
                    e_alu = alu_of(f3, w[30]);
                end
                OPC_FENCE: e_ctl = 18'b100;
                default:   e_ctl = {16'd0, !w[20], w[20]};
            endcase
        end
    endtask

    task automatic check_decode();
        logic [17:0] got;
        got = {rs1_rd_o, rs2_rd_o, rs1_zero_sel_o, rs2_imm_sel_o, pc_imm_sel_o,
               branch_o, jump_o, jump_alu_o, mem_req_o, mem_wr_o, mem_sign_ext_o,
               pc_alu_sel_o, mem_cal_sel_o, rd_wr_o, ill_inst_o, fence_o, ecall_o,
               ebreak_o};
        check_val("rs1_addr_o", rs1_addr_o, inst_i[19:15]);
        check_val("rs2_addr_o", rs2_addr_o, inst_i[24:20]);
        check_val("rd_addr_o", rd_addr_o, inst_i[11:7]);
        check_val("imm_o", imm_o, e_imm);
        check_val("alu_op_o", alu_op_o, e_alu);
        check_val("mem_byte_o", mem_byte_o, e_byte);
        check_val("ill_inst_o", ill_inst_o, e_ctl[3]);
        check_val("control outputs", got, e_ctl);
    endtask

    function automatic logic [31:0] gen_inst();
        logic [31:0] w;
        logic [3:0] sel;
        w = rand_bits(32);
        sel = rand_bits(4);
        case (sel)
            4'd0:  w[6:0] = OPC_LUI;
            4'd1:  w[6:0] = OPC_AUIPC;
            4'd2:  w[6:0] = OPC_JAL;
            4'd3:  w = {w[31:15], rand_bit() ? 3'd0 : w[14:12], w[11:7], OPC_JALR};
            4'd4:  w[6:0] = OPC_BRANCH;
            4'd5:  w[6:0] = OPC_LOAD;
            4'd6:  w[6:0] = OPC_STORE;
            4'd7:  w = {rand_bit() ? 7'h20 : 7'h00, w[24:7], OPC_IMM};
            4'd8:  w[6:0] = OPC_IMM;
            4'd9:  w = {rand_bit() ? 7'h20 : 7'h00, w[24:7], OPC_REG};
            4'd10: w = {w[31:15], rand_bit() ? 3'd0 : w[14:12], w[11:7], OPC_FENCE};
            4'd11: w = rand_bit() ? 32'h0000_0073 : 32'h0010_0073;
            4'd12: w[6:0] = OPC_SYS;
            default: ;
        endcase
        return w;
    endfunction

    initial begin
        logic [31:0] w;
        logic        we;
        reg_addr_t   a;
        xlen_t       d;
        xlen_t       exp;
        arst_n_i = 1'b0;
        inst_i = '0;
        inst_valid_i = 1'b0;
        rd_wr_i = 1'b0;
        rd_addr_i = '0;
        rd_data_i = '0;
        halted_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // Write-back and bypass
        for (int i = 0; i < N_REG; i++) begin
            @(negedge clk);
            rd_wr_i = rand_bit();
            rd_addr_i = rand_bits(5);
            rd_data_i = rand_bits(32);
            w = rand_bits(32);
            if (rand_bit()) begin
                w[19:15] = rd_addr_i;
            end
            if (rand_bit()) begin
                w[24:20] = rd_addr_i;
            end
            inst_i = w;
            #(PERIOD / 4);
            exp = (rd_wr_i && rd_addr_i == w[19:15]) ? rd_data_i : regs[w[19:15]];
            check_val("rs1_data_o", rs1_data_o, (w[19:15] == 5'd0) ? 32'd0 : exp);
            exp = (rd_wr_i && rd_addr_i == w[24:20]) ? rd_data_i : regs[w[24:20]];
            check_val("rs2_data_o", rs2_data_o, (w[24:20] == 5'd0) ? 32'd0 : exp);
            if (rd_wr_i && rd_addr_i != 5'd0) begin
                regs[rd_addr_i] = rd_data_i;
            end
        end

        // Decode of legal, illegal and idle words
        for (int i = 0; i < N_DEC; i++) begin
            @(negedge clk);
            rd_wr_i = 1'b0;
            inst_i = rand_bit() ? gen_inst() : rand_bits(32);
            inst_valid_i = (rand_bits(3) != 3'd0);
            #(PERIOD / 4);
            model_decode(inst_i, inst_valid_i);
            check_decode();
            check_val("rs1_data_o", rs1_data_o, regs[inst_i[19:15]]);
            check_val("rs2_data_o", rs2_data_o, regs[inst_i[24:20]]);
        end

        // Debug bus while halted with write-back pulses ignored
        @(negedge clk);
        halted_i = 1'b1;
        inst_valid_i = 1'b0;
        for (int i = 0; i < N_DBG; i++) begin
            @(negedge clk);
            we = rand_bit();
            a = rand_bits(5);
            d = rand_bits(32);
            {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = {2'b11, we, a, d};
            rd_wr_i = rand_bit();
            rd_addr_i = a;
            rd_data_i = rand_bits(32);
            w = rand_bits(32);
            w[19:15] = a;
            inst_i = w;
            #(PERIOD / 4);
            check_val("wb_ack_o", wb_ack_o, 1'b0);
            check_val("wb_err_o", wb_err_o, 1'b0);
            exp = regs[a];
            if (we && a != 5'd0) begin
                regs[a] = d;
            end
            @(negedge clk);
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
            check_val("wb_ack_o", wb_ack_o, 1'b1);
            check_val("wb_err_o", wb_err_o, 1'b0);
            if (!we) begin
                check_val("wb_dat_o", wb_dat_o, exp);
            end
            check_val("rs1_data_o", rs1_data_o, regs[a]);
        end

        // Debug writes while running get an error response
        halted_i = 1'b0;
        rd_wr_i = 1'b0;
        for (int i = 0; i < N_ERR; i++) begin
            @(negedge clk);
            a = rand_bits(5);
            {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = {3'b111, a, rand_bits(32)};
            inst_i = {12'd0, a, 15'd0};
            @(negedge clk);
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
            check_val("wb_err_o", wb_err_o, 1'b1);
            check_val("wb_ack_o", wb_ack_o, 1'b0);
            check_val("rs1_data_o", rs1_data_o, regs[a]);
        end

        @(negedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/dbg_gpr_if.sv
rtl/rfu.sv
rtl/dec.sv
rtl/dbg_wb_slave.sv
rtl/idu.sv
bench/idu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= idu_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SRCS := $(filter-out +%,$(shell cat verilog.f)) rtl/cpu_defs.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): verilog.f $(SRCS)
	$(VERILATOR) --binary --top-module $(TOP) -f verilog.f --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
